// File: rtl/sys_io_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, enums and packed structs for the host
// command port, the board LEDs and the stereo mixer.
// Modules refer to these by scoped names.
////////////////////////////////////////////////////////////

package sys_io_pkg;

	// Audio sample width, default for the mixer channels
	parameter int SAMPLE_W = 16;

	// Host data word width
	parameter int IO_W = 16;

	// Number of board LEDs
	parameter int LED_W = 8;

	// Attenuation field, bit 4 is mute, bits 3:0 the shift
	parameter int ATT_W = 5;

	// Host commands handled here
	typedef enum logic [7:0] {
		CMD_LED = 8'h25,
		CMD_VOL = 8'h26
	} cmd_e;

	// Cross-feed modes of the mixer
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_QUARTER = 2'd1,
		MIX_HALF    = 2'd2,
		MIX_MONO    = 2'd3
	} mix_e;

	// Host port as seen by the fabric
	typedef struct packed {
		logic            select;
		logic            strobe;
		logic [IO_W-1:0] data;
	} host_io_t;

	// LED indications coming from the core
	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
		logic       pll_locked;
	} core_led_t;

	// Core audio samples and settings
	typedef struct packed {
		logic [SAMPLE_W-1:0] left;
		logic [SAMPLE_W-1:0] right;
		logic                is_signed;
		mix_e                mix;
	} core_audio_t;

endpackage

// File: rtl/hps_cmd_regs.sv
////////////////////////////////////////////////////////////
// Host command decoder for the user command channel.
// Holds the volume attenuation and the LED override
// mask/state, and builds the registered board LED vector.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module hps_cmd_regs (
	input  logic                            i_clk,
	input  logic                            i_resetd,
	input  sys_io_pkg::host_io_t            i_host,
	input  sys_io_pkg::core_led_t           i_core_led,
	output logic [sys_io_pkg::ATT_W-1:0]    o_att,
	output logic [sys_io_pkg::LED_W-1:0]    o_led
);

	// Registered host port
	logic                        sel_q;
	logic                        stb_q;
	logic                        stb_d;
	logic [sys_io_pkg::IO_W-1:0] data_q;

	logic                        rise;
	logic                        data_edge;
	logic                        led_wr;
	logic                        vol_wr;

	// Command phase
	logic                        has_cmd;
	sys_io_pkg::cmd_e            cmd;

	// Host writable registers
	logic [sys_io_pkg::LED_W-1:0] led_mask;
	logic [sys_io_pkg::LED_W-1:0] led_state;
	logic [sys_io_pkg::ATT_W-1:0] att_reg;
	logic [sys_io_pkg::LED_W-1:0] led_dflt;

	////////////////////////////////////////////////////////////
	// Strobe edge detection
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			sel_q <= 1'b0;
			stb_q <= 1'b0;
			stb_d <= 1'b0;
		end else begin
			sel_q <= i_host.select;
			stb_q <= i_host.strobe;
			stb_d <= stb_q;
		end
	end

	always_ff @(posedge i_clk) begin
		data_q <= i_host.data;
	end

	assign rise      = stb_q & ~stb_d;
	assign data_edge = sel_q & rise & has_cmd;
	assign led_wr    = data_edge & (cmd == sys_io_pkg::CMD_LED);
	assign vol_wr    = data_edge & (cmd == sys_io_pkg::CMD_VOL);

	////////////////////////////////////////////////////////////
	// Command phase and register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			has_cmd <= 1'b0;
		end else if (!sel_q) begin
			has_cmd <= 1'b0;
		end else if (rise) begin
			has_cmd <= 1'b1;
		end
	end

	// First edge in a select window carries the command byte
	always_ff @(posedge i_clk) begin
		if (sel_q && rise && !has_cmd) begin
			cmd <= sys_io_pkg::cmd_e'(data_q[7:0]);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			led_mask  <= '0;
			led_state <= '0;
			att_reg   <= '0;
		end else begin
			if (led_wr) begin
				{led_mask, led_state} <= data_q;
			end
			if (vol_wr) begin
				att_reg <= data_q[sys_io_pkg::ATT_W-1:0];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			o_att <= '0;
		end else begin
			o_att <= att_reg;
		end
	end

	////////////////////////////////////////////////////////////
	// Board LEDs
	////////////////////////////////////////////////////////////

	// Odd positions stay dark
	always_comb begin
		led_dflt    = '0;
		led_dflt[0] = i_core_led.user;
		led_dflt[2] = i_core_led.disk[0];
		led_dflt[4] = i_core_led.power[1] ? i_core_led.power[0] : 1'b1;
		led_dflt[6] = i_core_led.pll_locked;
	end

	// Override bits win over the core defaults
	always_ff @(posedge i_clk) begin
		o_led <= (led_mask & led_state) | (~led_mask & led_dflt);
	end

	// Attenuation only moves two clocks after a volume write
	a_att_write_only: assert property (@(posedge i_clk) disable iff (i_resetd)
		$changed(o_att) |-> $past(vol_wr, 2));

endmodule

// File: rtl/aud_mix_channel.sv
////////////////////////////////////////////////////////////
// One stereo mixer channel. Filters glitches on the core
// sample, adds the host stream, cross-feeds the other
// channel, applies volume and clamps to the sample width.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module aud_mix_channel #(
	parameter int SAMPLE_W = sys_io_pkg::SAMPLE_W
) (
	input  logic                         clk,
	input  logic                         resetd,
	input  logic [SAMPLE_W-1:0]          i_core_sample,
	input  logic [SAMPLE_W-1:0]          i_host_sample,
	input  logic                         i_is_signed,
	input  sys_io_pkg::mix_e             i_mix,
	input  logic [sys_io_pkg::ATT_W-1:0] i_att,
	input  logic [SAMPLE_W-1:0]          i_pre_in,
	output logic [SAMPLE_W-1:0]          o_pre_out,
	output logic [SAMPLE_W-1:0]          o_sample
);

	// Stabilizer taps and accepted sample
	logic [SAMPLE_W-1:0] d1;
	logic [SAMPLE_W-1:0] d2;
	logic [SAMPLE_W-1:0] ca;

	// One bit of headroom through the arithmetic
	logic signed [SAMPLE_W:0] a1;
	logic signed [SAMPLE_W:0] a2;
	logic signed [SAMPLE_W:0] a3;
	logic signed [SAMPLE_W:0] a4;
	logic signed [SAMPLE_W:0] host_x;
	logic signed [SAMPLE_W:0] pre_x;

	assign host_x = {i_host_sample[SAMPLE_W-1], i_host_sample};
	assign pre_x  = {i_pre_in[SAMPLE_W-1], i_pre_in};

	////////////////////////////////////////////////////////////
	// Glitch filter
	////////////////////////////////////////////////////////////

	// New value taken only once two delayed copies agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core_sample;
			d2 <= d1;
			if (d1 == d2) begin
				ca <= d1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Mix pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1        <= '0;
			a2        <= '0;
			a3        <= '0;
			a4        <= '0;
			o_pre_out <= '0;
			o_sample  <= '0;
		end else begin
			// Unsigned samples lose their LSB to fit the sign bit
			a1 <= i_is_signed ? {ca[SAMPLE_W-1], ca} : {2'b00, ca[SAMPLE_W-1:1]};
			a2 <= a1 + host_x;

			o_pre_out <= a2[SAMPLE_W:1];

			case (i_mix)
				sys_io_pkg::MIX_QUARTER: a3 <= a2 - (a2 >>> 3) + (pre_x >>> 2);
				sys_io_pkg::MIX_HALF:    a3 <= a2 - (a2 >>> 2) + (pre_x >>> 1);
				sys_io_pkg::MIX_MONO:    a3 <= (a2 >>> 1) + pre_x;
				default:                 a3 <= a2;
			endcase

			if (i_att[sys_io_pkg::ATT_W-1]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[sys_io_pkg::ATT_W-2:0];
			end

			// Saturate when the top two bits disagree
			if (a4[SAMPLE_W] != a4[SAMPLE_W-1]) begin
				o_sample <= {a4[SAMPLE_W], {(SAMPLE_W-1){~a4[SAMPLE_W]}}};
			end else begin
				o_sample <= a4[SAMPLE_W-1:0];
			end
		end
	end

	// Mute reaches the output through the last two stages
	a_mute_silence: assert property (@(posedge clk) disable iff (resetd)
		i_att[sys_io_pkg::ATT_W-1] [*4] |-> o_sample == '0);

endmodule

// File: rtl/sys_io_top.sv
////////////////////////////////////////////////////////////
// Top of the board support slice. Joins the host command
// registers with the left and right mixer channels, which
// exchange their pre-mix samples for cross-feed.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sys_io_top #(
	parameter int SAMPLE_W = sys_io_pkg::SAMPLE_W
) (
	input  logic                         clk,
	input  logic                         resetd,
	input  sys_io_pkg::host_io_t         i_host,
	input  sys_io_pkg::core_led_t        i_core_led,
	input  sys_io_pkg::core_audio_t      i_core_audio,
	input  logic [SAMPLE_W-1:0]          i_host_left,
	input  logic [SAMPLE_W-1:0]          i_host_right,
	output logic [sys_io_pkg::LED_W-1:0] o_led,
	output logic [SAMPLE_W-1:0]          o_left,
	output logic [SAMPLE_W-1:0]          o_right
);

	logic [sys_io_pkg::ATT_W-1:0] vol_att;
	logic [SAMPLE_W-1:0]          pre_left;
	logic [SAMPLE_W-1:0]          pre_right;

	// Host command port
	hps_cmd_regs i_hps_cmd_regs (
		.i_clk      (clk),
		.i_resetd   (resetd),
		.i_host     (i_host),
		.i_core_led (i_core_led),
		.o_att      (vol_att),
		.o_led      (o_led)
	);

	////////////////////////////////////////////////////////////
	// Stereo mixer, pre-mix outputs cross over
	////////////////////////////////////////////////////////////

	aud_mix_channel #(
		.SAMPLE_W (SAMPLE_W)
	) i_mix_left (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_sample (i_core_audio.left),
		.i_host_sample (i_host_left),
		.i_is_signed   (i_core_audio.is_signed),
		.i_mix         (i_core_audio.mix),
		.i_att         (vol_att),
		.i_pre_in      (pre_right),
		.o_pre_out     (pre_left),
		.o_sample      (o_left)
	);

	aud_mix_channel #(
		.SAMPLE_W (SAMPLE_W)
	) i_mix_right (
		.clk           (clk),
		.resetd        (resetd),
		.i_core_sample (i_core_audio.right),
		.i_host_sample (i_host_right),
		.i_is_signed   (i_core_audio.is_signed),
		.i_mix         (i_core_audio.mix),
		.i_att         (vol_att),
		.i_pre_in      (pre_left),
		.o_pre_out     (pre_right),
		.o_sample      (o_right)
	);

endmodule

// File: testbench/tb_ref_model.svh
////////////////////////////////////////////////////////////
// Reference model of the board LEDs and the stereo mixer.
// Included inside the testbench module.
////////////////////////////////////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Core defaults on even LEDs with host override where the mask is set
function automatic logic [7:0] led_expect(input sys_io_pkg::core_led_t c,
	input logic [7:0] mask, input logic [7:0] state);
	logic [7:0] dflt;
	dflt    = 8'h00;
	dflt[0] = c.user;
	dflt[2] = c.disk[0];
	dflt[4] = c.power[1] ? c.power[0] : 1'b1;
	dflt[6] = c.pll_locked;
	return (mask & state) | (~mask & dflt);
endfunction

// Core sample plus host sample before any cross-feed
function automatic int mix_sum(input logic [15:0] s, input logic [15:0] h,
	input logic sgn);
	int core_v;
	if (sgn) begin
		core_v = int'($signed(s));
	end else begin
		core_v = int'(s >> 1);
	end
	return core_v + int'($signed(h));
endfunction

// One channel output from its own sum and the other channel's sum
function automatic logic [15:0] chan_expect(input int sum, input int other_sum,
	input sys_io_pkg::mix_e mix, input logic [4:0] att);
	int pre_in;
	int v;
	pre_in = other_sum >>> 1;
	case (mix)
		sys_io_pkg::MIX_QUARTER: v = sum - (sum >>> 3) + (pre_in >>> 2);
		sys_io_pkg::MIX_HALF:    v = sum - (sum >>> 2) + (pre_in >>> 1);
		sys_io_pkg::MIX_MONO:    v = (sum >>> 1) + pre_in;
		default:                 v = sum;
	endcase
	v = att[4] ? 0 : (v >>> att[3:0]);
	// Clamp to the signed 16-bit range
	if (v > 32767) begin
		v = 32767;
	end else if (v < -32768) begin
		v = -32768;
	end
	return v[15:0];
endfunction

`endif

// File: testbench/tb_sys_io.sv
////////////////////////////////////////////////////////////
// Testbench of the board support slice. Writes host
// commands, drives LED indications and audio samples, and
// compares LEDs and mixer outputs with the reference model.
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_sys_io;

	localparam int CLK_PERIOD = 100;
	localparam int SEED       = 90;
	localparam int N_RST      = 8;
	localparam int N_LED      = 8;
	localparam int N_MIX      = 24;
	localparam int N_XF       = 6;
	localparam int N_MUTE     = 4;
	localparam int N_STEPS    = N_RST + N_LED + 4 + N_MIX + 4 * N_XF + N_MUTE;

	logic                    clk;
	logic                    resetd;
	sys_io_pkg::host_io_t    host;
	sys_io_pkg::core_led_t   core_led;
	sys_io_pkg::core_audio_t core_audio;
	logic [15:0]             host_left;
	logic [15:0]             host_right;
	logic [7:0]              led;
	logic [15:0]             left;
	logic [15:0]             right;

	// Model of the host registers
	logic [7:0]  m_mask;
	logic [7:0]  m_state;
	logic [4:0]  m_att;

	logic        check_req;
	logic [7:0]  exp_led;
	logic [15:0] exp_left;
	logic [15:0] exp_right;
	int          errors = 0;
	int          checks = 0;

	`include "tb_ref_model.svh"

	sys_io_top #(
		.SAMPLE_W (sys_io_pkg::SAMPLE_W)
	) i_sys_io_top (
		.clk          (clk),
		.resetd       (resetd),
		.i_host       (host),
		.i_core_led   (core_led),
		.i_core_audio (core_audio),
		.i_host_left  (host_left),
		.i_host_right (host_right),
		.o_led        (led),
		.o_left       (left),
		.o_right      (right)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Compare process sampling on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (check_req) begin
			checks = checks + 1;
			if (led !== exp_led) begin
				$display("[FAIL] o_led got %h expected %h", led, exp_led);
				errors = errors + 1;
			end
			if (left !== exp_left) begin
				$display("[FAIL] o_left got %h expected %h", left, exp_left);
				errors = errors + 1;
			end
			if (right !== exp_right) begin
				$display("[FAIL] o_right got %h expected %h", right, exp_right);
				errors = errors + 1;
			end
		end
	end

	task automatic request_check();
		check_req <= 1'b1;
		@(posedge clk);
		check_req <= 1'b0;
	endtask

	task automatic host_strobe(input logic [15:0] data);
		host.data   <= data;
		host.strobe <= 1'b1;
		repeat (3) @(posedge clk);
		host.strobe <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// Command byte then one data word inside one select window
	task automatic host_write(input logic [7:0] cmd, input logic [15:0] data);
		host.select <= 1'b1;
		@(posedge clk);
		host_strobe({8'h00, cmd});
		host_strobe(data);
		host.select <= 1'b0;
		@(posedge clk);
		if (cmd == sys_io_pkg::CMD_LED) begin
			m_mask  = data[15:8];
			m_state = data[7:0];
		end else if (cmd == sys_io_pkg::CMD_VOL) begin
			m_att = data[4:0];
		end
	endtask

	task automatic check_leds();
		core_led <= 6'($urandom);
		repeat (2) @(posedge clk);
		exp_led = led_expect(core_led, m_mask, m_state);
		request_check();
	endtask

	task automatic check_mixer(input logic [15:0] l, input logic [15:0] r,
		input logic [15:0] hl, input logic [15:0] hr, input logic sgn,
		input sys_io_pkg::mix_e mix);
		int sum_l;
		int sum_r;
		core_audio.left      <= l;
		core_audio.right     <= r;
		core_audio.is_signed <= sgn;
		core_audio.mix       <= mix;
		host_left            <= hl;
		host_right           <= hr;
		// Cross-feed settle time
		repeat (16) @(posedge clk);
		sum_l       = mix_sum(l, hl, sgn);
		sum_r       = mix_sum(r, hr, sgn);
		exp_left    = chan_expect(sum_l, sum_r, mix, m_att);
		exp_right   = chan_expect(sum_r, sum_l, mix, m_att);
		exp_led     = led_expect(core_led, m_mask, m_state);
		request_check();
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		clk         = 1'b0;
		resetd      = 1'b1;
		host        = '0;
		core_led    = '0;
		core_audio  = '0;
		// Host audio held nonzero through reset
		host_left   = 16'h4321;
		host_right  = 16'hbcde;
		m_mask      = '0;
		m_state     = '0;
		m_att       = '0;
		check_req   = 1'b0;
		exp_led     = '0;
		exp_left    = '0;
		exp_right   = '0;
		repeat (10) @(posedge clk);
		resetd     <= 1'b0;
		host_left  <= '0;
		host_right <= '0;
		@(posedge clk);

		// Silent outputs and core defaults after reset
		for (int i = 0; i < N_RST; i++) begin
			check_leds();
		end

		for (int i = 0; i < N_LED; i++) begin
			host_write(sys_io_pkg::CMD_LED, 16'($urandom));
			repeat (4) check_leds();
		end

		// Volume write, unknown command, select dropped before data
		host_write(sys_io_pkg::CMD_VOL, 16'h0003);
		check_mixer(16'h7000, 16'h9000, 16'h0800, 16'hf800, 1'b1, sys_io_pkg::MIX_NONE);
		host_write(8'h27, 16'h1fff);
		check_mixer(16'h7000, 16'h9000, 16'h0800, 16'hf800, 1'b1, sys_io_pkg::MIX_NONE);
		host.select <= 1'b1;
		@(posedge clk);
		host_strobe({8'h00, sys_io_pkg::CMD_VOL});
		host.select <= 1'b0;
		@(posedge clk);
		host.select <= 1'b1;
		@(posedge clk);
		host_strobe(16'h0007);
		host.select <= 1'b0;
		@(posedge clk);
		check_mixer(16'h7000, 16'h9000, 16'h0800, 16'hf800, 1'b1, sys_io_pkg::MIX_NONE);
		check_mixer(16'h4000, 16'h2000, 16'h0000, 16'h0000, 1'b0, sys_io_pkg::MIX_NONE);

		// First few at full scale to hit the clamp
		for (int i = 0; i < N_MIX; i++) begin
			host_write(sys_io_pkg::CMD_VOL, (i < 4) ? 16'(i) : 16'($urandom % 16));
			if (i < 4) begin
				check_mixer(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 1'b1,
					sys_io_pkg::MIX_NONE);
			end else begin
				check_mixer(16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
					1'($urandom), sys_io_pkg::MIX_NONE);
			end
		end

		for (int m = 0; m < 4; m++) begin
			host_write(sys_io_pkg::CMD_VOL, 16'($urandom % 4));
			repeat (N_XF) check_mixer(16'($urandom), 16'($urandom), 16'($urandom),
				16'($urandom), 1'($urandom), sys_io_pkg::mix_e'(m));
		end

		host_write(sys_io_pkg::CMD_VOL, 16'h0010 | 16'($urandom % 16));
		repeat (N_MUTE) check_mixer(16'($urandom), 16'($urandom), 16'($urandom),
			16'($urandom), 1'($urandom), sys_io_pkg::mix_e'($urandom % 4));

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog allowing 40 clocks per test step
	initial begin
		#(N_STEPS * 40 * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d clocks", N_STEPS * 40);
		$display("Something failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+testbench
rtl/sys_io_pkg.sv
rtl/hps_cmd_regs.sv
rtl/aud_mix_channel.sv
rtl/sys_io_top.sv
testbench/tb_sys_io.sv

// File: Makefile
# Verilator build and run of the board support slice

VERILATOR  ?= verilator
TOP        ?= tb_sys_io
SEED_FLAGS ?= +verilator+seed+90
VFLAGS     ?= --binary --timing --assert
OBJ_DIR    ?= obj_dir
PASS_MSG   := Everything OK

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, SEED_FLAGS, VFLAGS, OBJ_DIR"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
